//--- source/afu_pkg.sv
package afu_pkg;

    // ====================
    // widths and types
    // ====================

    // a line is 64 bytes, so the low 6 bits of a byte address are dropped
    localparam int CL_BYTE_IDX_BITS = 6;

    typedef logic [47:0]  byte_addr_t;
    typedef logic [41:0]  cl_addr_t;
    typedef logic [511:0] line_data_t;
    typedef logic [15:0]  count_t;
    typedef logic [31:0]  hash_t;
    typedef logic [2:0]   csr_idx_t;
    typedef logic [63:0]  csr_data_t;

    // register map
    localparam csr_idx_t CSR_INPUT_ADDR   = 3'd0;
    localparam csr_idx_t CSR_INPUT_LENGTH = 3'd1;
    localparam csr_idx_t CSR_OUTPUT_ADDR  = 3'd2;
    localparam csr_idx_t CSR_COUNT        = 3'd3;
    localparam csr_idx_t CSR_START_DONE   = 3'd4;

    // djb2-style hash, xor variant
    localparam hash_t HASH_SEED = 32'h0000_1505;
    localparam hash_t HASH_MULT = 32'd33;

    // software spins on this word of the result line
    localparam logic [63:0] RESULT_FLAG = 64'd1;

    typedef struct packed {
        logic     valid;
        cl_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       valid;
        line_data_t data;
    } rd_rsp_t;

    typedef struct packed {
        logic       valid;
        cl_addr_t   addr;
        line_data_t data;
    } wr_req_t;

    typedef struct packed {
        logic      en;
        csr_idx_t  idx;
        csr_data_t data;
    } csr_wr_t;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_RUN,
        ST_WRITE
    } ctrl_state_t;

    // strip the byte offset bits
    function automatic cl_addr_t byte_to_cl_addr(byte_addr_t addr);
        return addr[CL_BYTE_IDX_BITS +: $bits(cl_addr_t)];
    endfunction

    // one hash step, product truncated to 32 bits
    function automatic hash_t hash_step(hash_t cur, logic [31:0] word);
        return (cur * HASH_MULT) ^ word;
    endfunction

endpackage

//--- source/afu_csr_regs.sv
`timescale 1ns/100ps

module afu_csr_regs
(
    input  logic                 clk,
    input  logic                 reset,

    // host side
    input  afu_pkg::csr_wr_t     csr_wr,
    input  afu_pkg::csr_idx_t    csr_rd_idx,
    output afu_pkg::csr_data_t   csr_rd_data,

    // status from the datapath
    input  logic                 done,
    input  afu_pkg::count_t      lines_received,

    // configuration toward the datapath
    output afu_pkg::cl_addr_t    cfg_input_addr,
    output afu_pkg::cl_addr_t    cfg_output_addr,
    output afu_pkg::count_t      cfg_length,
    output logic                 start
);
    import afu_pkg::*;

    // ====================
    // configuration writes
    // ====================

    // payload registers, only loaded on their own index
    always_ff @(posedge clk)
    begin
        if (csr_wr.en)
        begin
            case (csr_wr.idx)
                CSR_INPUT_ADDR:
                    cfg_input_addr <= byte_to_cl_addr(csr_wr.data[$bits(byte_addr_t)-1:0]);
                CSR_INPUT_LENGTH:
                    cfg_length <= csr_wr.data[$bits(count_t)-1:0];
                CSR_OUTPUT_ADDR:
                    cfg_output_addr <= byte_to_cl_addr(csr_wr.data[$bits(byte_addr_t)-1:0]);
                default:
                    ;
            endcase
        end
    end

    // start pulse, one cycle after the write to index 4
    always_ff @(posedge clk)
    begin
        if (reset)
            start <= 1'b0;
        else
            start <= csr_wr.en && (csr_wr.idx == CSR_START_DONE);
    end

    // ====================
    // status reads
    // ====================

    // no read strobe, value is presented every cycle
    always_comb
    begin
        case (csr_rd_idx)
            CSR_COUNT:      csr_rd_data = csr_data_t'(lines_received);
            CSR_START_DONE: csr_rd_data = csr_data_t'(done);
            default:        csr_rd_data = '0;
        endcase
    end

endmodule

//--- source/afu_control.sv
`timescale 1ns/100ps

module afu_control
(
    input  logic               clk,
    input  logic               reset,

    input  logic               start,
    input  afu_pkg::count_t    cfg_length,
    input  afu_pkg::cl_addr_t  cfg_output_addr,

    // progress from the response side
    input  afu_pkg::count_t    lines_received,
    input  afu_pkg::hash_t     hash_value,

    // result write channel
    input  logic               wr_almfull,

    output logic               launch,
    output logic               done,
    output afu_pkg::wr_req_t   wr_req
);
    import afu_pkg::*;

    ctrl_state_t state;

    // registered write request fields
    logic       wr_valid;
    cl_addr_t   wr_addr;
    line_data_t wr_data;

    // result is sent on the first cycle the write channel has room
    logic       wr_fire;

    // start only counts while idle, a busy run ignores it
    assign launch  = start && (state == ST_IDLE);
    assign wr_fire = (state == ST_WRITE) && !wr_almfull;

    // ====================
    // state machine
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (launch)
                        state <= ST_RUN;
                end

                ST_RUN:
                begin
                    // all lines folded into the hash, zero length leaves at once
                    if (lines_received == cfg_length)
                        state <= ST_WRITE;
                end

                ST_WRITE:
                begin
                    // hold here while the write channel is almost full
                    if (wr_fire)
                        state <= ST_IDLE;
                end

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // done rises with the result write and falls at the next launch
    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else if (launch)
            done <= 1'b0;
        else if (wr_fire)
            done <= 1'b1;
    end

    // ====================
    // result write
    // ====================

    // single-cycle valid
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_valid <= 1'b0;
        else
            wr_valid <= wr_fire;
    end

    // flag in the low word, hash in bits 95:64, rest zero
    always_ff @(posedge clk)
    begin
        wr_addr <= cfg_output_addr;
        wr_data <= line_data_t'({hash_value, RESULT_FLAG});
    end

    assign wr_req = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

//--- source/afu_read_engine.sv
`timescale 1ns/100ps

module afu_read_engine
#(
    parameter int MAX_OUTSTANDING = 8
)
(
    input  logic               clk,
    input  logic               reset,

    input  logic               launch,
    input  afu_pkg::cl_addr_t  cfg_input_addr,
    input  afu_pkg::count_t    cfg_length,

    // read channel back-pressure and response strobe
    input  logic               rd_almfull,
    input  logic               rsp_valid,

    output afu_pkg::rd_req_t   rd_req
);
    import afu_pkg::*;

    // wide enough to hold MAX_OUTSTANDING itself
    localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [OUT_W-1:0] OUT_LIMIT = OUT_W'(MAX_OUTSTANDING);

    // walk state
    cl_addr_t         next_addr;
    count_t           remaining;

    // requests sent whose response has not come back yet
    logic [OUT_W-1:0] outstanding;

    // request fields
    logic             req_valid;
    cl_addr_t         req_addr;

    logic             issue;

    // one request per cycle when lines are left, the channel has room
    // and the in-flight limit is not reached
    assign issue = (remaining != '0) && !rd_almfull && (outstanding < OUT_LIMIT);

    // ====================
    // address walk
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= '0;
        end
        else if (launch)
        begin
            next_addr <= cfg_input_addr;
            remaining <= cfg_length;
        end
        else if (issue)
        begin
            // sequential lines, one per request
            next_addr <= next_addr + cl_addr_t'(1);
            remaining <= remaining - count_t'(1);
        end
    end

    // in-flight count, up on request and down on response
    always_ff @(posedge clk)
    begin
        if (reset)
            outstanding <= '0;
        else
            outstanding <= outstanding + OUT_W'(issue) - OUT_W'(rsp_valid);
    end

    // ====================
    // request output
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
            req_valid <= 1'b0;
        else
            req_valid <= issue;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            req_addr <= next_addr;
    end

    assign rd_req = '{valid: req_valid, addr: req_addr};

endmodule

//--- source/afu_rsp_hash.sv
`timescale 1ns/100ps

module afu_rsp_hash
(
    input  logic              clk,
    input  logic              reset,

    input  logic              launch,
    input  afu_pkg::rd_rsp_t  rd_rsp,

    output afu_pkg::hash_t    hash_value,
    output afu_pkg::count_t   lines_received
);
    import afu_pkg::*;

    // low word of each line feeds the hash
    logic [31:0] rsp_word;

    assign rsp_word = rd_rsp.data[31:0];

    // ====================
    // running hash
    // ====================

    // responses arrive in request order, the hash depends on it
    always_ff @(posedge clk)
    begin
        if (reset || launch)
            hash_value <= HASH_SEED;
        else if (rd_rsp.valid)
            hash_value <= hash_step(hash_value, rsp_word);
    end

    // ====================
    // received line count
    // ====================

    // updates at the same edge as the hash, so the control sees both together
    always_ff @(posedge clk)
    begin
        if (reset || launch)
        begin
            lines_received <= '0;
        end
        else if (rd_rsp.valid)
        begin
            lines_received <= lines_received + count_t'(1);
        end
    end

endmodule

//--- source/afu_top.sv
`timescale 1ns/100ps

module afu_top
#(
    parameter int MAX_OUTSTANDING = 8
)
(
    input  logic                clk,
    input  logic                reset,

    // host register access
    input  afu_pkg::csr_wr_t    csr_wr,
    input  afu_pkg::csr_idx_t   csr_rd_idx,
    output afu_pkg::csr_data_t  csr_rd_data,

    // memory read channel
    output afu_pkg::rd_req_t    rd_req,
    input  logic                rd_almfull,
    input  afu_pkg::rd_rsp_t    rd_rsp,

    // memory write channel
    output afu_pkg::wr_req_t    wr_req,
    input  logic                wr_almfull
);
    import afu_pkg::*;

    // configuration
    cl_addr_t cfg_input_addr;
    cl_addr_t cfg_output_addr;
    count_t   cfg_length;
    logic     start;

    // control and status
    logic     launch;
    logic     done;
    hash_t    hash_value;
    count_t   lines_received;

    // ====================
    // CSRs
    // ====================

    afu_csr_regs i_afu_csr_regs
    (
        .clk             (clk),
        .reset           (reset),
        .csr_wr          (csr_wr),
        .csr_rd_idx      (csr_rd_idx),
        .csr_rd_data     (csr_rd_data),
        .done            (done),
        .lines_received  (lines_received),
        .cfg_input_addr  (cfg_input_addr),
        .cfg_output_addr (cfg_output_addr),
        .cfg_length      (cfg_length),
        .start           (start)
    );

    // ====================
    // FSM
    // ====================

    afu_control i_afu_control
    (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .cfg_length      (cfg_length),
        .cfg_output_addr (cfg_output_addr),
        .lines_received  (lines_received),
        .hash_value      (hash_value),
        .wr_almfull      (wr_almfull),
        .launch          (launch),
        .done            (done),
        .wr_req          (wr_req)
    );

    // ====================
    // read and response
    // ====================

    afu_read_engine #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_afu_read_engine (
        .clk             (clk),
        .reset           (reset),
        .launch          (launch),
        .cfg_input_addr  (cfg_input_addr),
        .cfg_length      (cfg_length),
        .rd_almfull      (rd_almfull),
        .rsp_valid       (rd_rsp.valid),
        .rd_req          (rd_req)
    );

    afu_rsp_hash i_afu_rsp_hash
    (
        .clk             (clk),
        .reset           (reset),
        .launch          (launch),
        .rd_rsp          (rd_rsp),
        .hash_value      (hash_value),
        .lines_received  (lines_received)
    );

endmodule

//--- sim/tb_afu.sv
`timescale 1ns/100ps

module tb_afu;
    import afu_pkg::*;

    localparam int MAX_OUT     = 4;
    localparam int MEM_LINES   = 64;
    localparam int RUN_TIMEOUT = 2000;
    localparam int NUM_RUNS    = 6;

    logic       clk = 1'b0;
    logic       reset;
    csr_wr_t    csr_wr;
    csr_idx_t   csr_rd_idx;
    csr_data_t  csr_rd_data;
    rd_req_t    rd_req;
    logic       rd_almfull;
    rd_rsp_t    rd_rsp;
    wr_req_t    wr_req;
    logic       wr_almfull;

    // random line contents, indexed by the low line address bits
    line_data_t mem_lines [MEM_LINES];
    // line addresses requested and not yet answered, oldest first
    cl_addr_t   pending [$];
    int         rsp_gap;

    // expected values of the current run
    cl_addr_t   exp_in_addr;
    cl_addr_t   exp_out_addr;
    count_t     exp_len;
    hash_t      exp_hash;
    logic       run_active;

    // monitor state
    int         rd_count = 0;
    int         wr_count = 0;
    int         in_flight = 0;
    logic       prev_rd_almfull = 1'b0;
    logic       prev_wr_almfull = 1'b0;

    afu_top #(
        .MAX_OUTSTANDING (MAX_OUT)
    ) i_afu_top (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (csr_wr),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .rd_req      (rd_req),
        .rd_almfull  (rd_almfull),
        .rd_rsp      (rd_rsp),
        .wr_req      (wr_req),
        .wr_almfull  (wr_almfull)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ====================
    // helpers
    // ====================

    // the line address is folded into every 64-bit word of the line
    function automatic line_data_t line_at(cl_addr_t addr);
        line_data_t tag;
        tag = {8{64'(addr)}};
        return mem_lines[addr[5:0]] ^ tag;
    endfunction

    // hash over the low words of len lines starting at base
    function automatic hash_t expected_hash(cl_addr_t base, count_t len);
        hash_t      h;
        line_data_t line;
        h = HASH_SEED;
        for (int k = 0; k < int'(len); k++)
        begin
            line = line_at(base + cl_addr_t'(k));
            h = hash_t'(h * HASH_MULT) ^ line[31:0];
        end
        return h;
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, RUN_TIMEOUT);
        $display("Done: errors found");
        $fatal(1, "stopped on timeout");
    endtask

    // called a little after a rising edge, returns at the same point
    task automatic write_csr(input csr_idx_t idx, input csr_data_t data);
        csr_wr.en   = 1'b1;
        csr_wr.idx  = idx;
        csr_wr.data = data;
        @(posedge clk);
        #2;
        csr_wr.en   = 1'b0;
    endtask

    // wr_count only moves on falling edges, so it is read on rising ones
    task automatic wait_result_write();
        int cycles;
        cycles = 0;
        while (wr_count == 0)
        begin
            if (cycles >= RUN_TIMEOUT)
                stop_on_timeout("result write");
            else
            begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    // ====================
    // memory model
    // ====================

    initial
    begin
        rd_rsp     = '0;
        rd_almfull = 1'b0;
        wr_almfull = 1'b0;
        rsp_gap    = 0;
        forever
        begin
            @(posedge clk);
            #2;
            rd_almfull   = ($urandom_range(0, 3) == 0);
            wr_almfull   = ($urandom_range(0, 1) == 0);
            rd_rsp.valid = 1'b0;
            // in order, 1 to 6 cycles between responses
            if (rsp_gap > 0)
            begin
                rsp_gap--;
            end
            else if (pending.size() > 0)
            begin
                rd_rsp.valid = 1'b1;
                rd_rsp.data  = line_at(pending.pop_front());
                rsp_gap      = $urandom_range(0, 5);
            end
            // a request seen here is answered a cycle later at the earliest
            if (rd_req.valid)
                pending.push_back(rd_req.addr);
        end
    end

    // ====================
    // monitor
    // ====================

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            check_value("rd_req.valid in reset", 64'(rd_req.valid), 64'd0);
            check_value("wr_req.valid in reset", 64'(wr_req.valid), 64'd0);
            check_value("done in reset", csr_rd_data, 64'd0);
        end
        else
        begin
            // start write seen, new run
            if (csr_wr.en && (csr_wr.idx == CSR_START_DONE))
            begin
                rd_count = 0;
                wr_count = 0;
            end
            if (rd_req.valid)
            begin
                check_value("rd_req after rd_almfull", 64'(prev_rd_almfull), 64'd0);
                check_value("read inside length", 64'(rd_count < int'(exp_len)), 64'd1);
                check_value("read address", 64'(rd_req.addr),
                            64'(exp_in_addr + cl_addr_t'(rd_count)));
                rd_count++;
                in_flight++;
            end
            if (rd_rsp.valid)
                in_flight--;
            check_value("reads in flight within limit", 64'(in_flight <= MAX_OUT), 64'd1);
            if (wr_req.valid)
            begin
                check_value("wr_req after wr_almfull", 64'(prev_wr_almfull), 64'd0);
                check_value("result address", 64'(wr_req.addr), 64'(exp_out_addr));
                check_value("result flag", wr_req.data[63:0], RESULT_FLAG);
                check_value("result hash", 64'(wr_req.data[95:64]), 64'(exp_hash));
                check_value("result upper bits", 64'(|wr_req.data[511:96]), 64'd0);
                wr_count++;
            end
            // done stays low from launch up to the result write
            if (run_active && (csr_rd_idx == CSR_START_DONE) && (wr_count == 0))
                check_value("done before result write", csr_rd_data, 64'd0);
        end
        prev_rd_almfull = rd_almfull;
        prev_wr_almfull = wr_almfull;
    end

    // ====================
    // stimulus
    // ====================

    initial
    begin
        byte_addr_t in_byte;
        byte_addr_t out_byte;
        count_t     len;
        void'($urandom(32'h23ce7f73));
        reset        = 1'b1;
        csr_wr       = '0;
        csr_rd_idx   = CSR_START_DONE;
        run_active   = 1'b0;
        exp_in_addr  = '0;
        exp_out_addr = '0;
        exp_len      = '0;
        exp_hash     = HASH_SEED;
        for (int i = 0; i < MEM_LINES; i++)
            for (int w = 0; w < 16; w++)
                mem_lines[i][w*32 +: 32] = $urandom;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_value("rd_req.valid after reset", 64'(rd_req.valid), 64'd0);
            check_value("wr_req.valid after reset", 64'(wr_req.valid), 64'd0);
            check_value("done after reset", csr_rd_data, 64'd0);
        end
        @(posedge clk);
        #2;

        for (int run = 0; run < NUM_RUNS; run++)
        begin
            // one run in the middle has zero length
            if (run == 3)
                len = '0;
            else
                len = count_t'($urandom_range(1, 20));
            in_byte      = byte_addr_t'({$urandom, $urandom});
            out_byte     = byte_addr_t'({$urandom, $urandom});
            exp_in_addr  = cl_addr_t'(in_byte >> CL_BYTE_IDX_BITS);
            exp_out_addr = cl_addr_t'(out_byte >> CL_BYTE_IDX_BITS);
            exp_len      = len;
            exp_hash     = expected_hash(exp_in_addr, len);

            write_csr(CSR_INPUT_ADDR, csr_data_t'(in_byte));
            write_csr(CSR_INPUT_LENGTH, csr_data_t'(len));
            write_csr(CSR_OUTPUT_ADDR, csr_data_t'(out_byte));
            write_csr(CSR_START_DONE, 64'd1);
            // launch clears done one edge after the start pulse
            @(posedge clk);
            #2;
            run_active = 1'b1;
            wait_result_write();
            #2;
            run_active = 1'b0;

            csr_rd_idx = CSR_COUNT;
            @(negedge clk);
            check_value("count register", csr_rd_data, 64'(len));
            @(posedge clk);
            #2;
            csr_rd_idx = CSR_START_DONE;
            @(negedge clk);
            check_value("done register", csr_rd_data, 64'd1);

            // a few quiet cycles to catch a second result write
            repeat (3) @(posedge clk);
            check_value("result writes per run", 64'(wr_count), 64'd1);
            check_value("reads per run", 64'(rd_count), 64'(len));
            check_value("reads left in flight", 64'(in_flight), 64'd0);
            #2;
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- src.f
source/afu_pkg.sv
source/afu_csr_regs.sv
source/afu_control.sv
source/afu_read_engine.sv
source/afu_rsp_hash.sv
source/afu_top.sv
sim/tb_afu.sv

//--- run.sh
#!/bin/sh
# build the afu testbench with Verilator and run it
# a failing run ends in $fatal, which gives a non-zero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f src.f \
    --top-module tb_afu \
    -o tb_afu

./obj_dir/tb_afu
